//--- Makefile
SIM_LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_uart_slave -o Vtb_uart_slave

run: build
	./obj_dir/Vtb_uart_slave | tee $(SIM_LOG)
	grep -q "Simulation finished: PASS" $(SIM_LOG)

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module uart_slave

clean:
	rm -rf obj_dir $(SIM_LOG)

.PHONY: all build run lint clean

//--- build.f
source/slave_pkg.sv
source/frame_decoder.sv
source/slave_sequencer.sv
source/write_channel.sv
source/read_channel.sv
source/uart_slave.sv
tests/tb_uart_slave.sv

//--- source/frame_decoder.sv
`timescale 1ns/1ps

module frame_decoder
    import slave_pkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic listen,
    output logic frame_hit,
    output logic frame_write
);

    typedef logic [$clog2(CON_BITS)-1:0] frame_cnt_t;

    // bits taken so far, the newest one arrives on control
    logic [CON_BITS-2:0] frame_sr;
    logic [CON_BITS-1:0] frame_full;
    frame_cnt_t          bit_cnt;
    logic                capturing;
    logic                last_bit;
    logic                start_ok;
    slave_id_t           frame_id;

    assign frame_full = {frame_sr, control};
    assign last_bit   = capturing && (bit_cnt == frame_cnt_t'(CON_BITS - 1));
    assign frame_id   = frame_full[S_ID_WIDTH:1];
    assign start_ok   = (frame_full[CON_BITS-1 -: 3] == START_CODE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            capturing   <= 1'b0;
            bit_cnt     <= '0;
            frame_hit   <= 1'b0;
            frame_write <= 1'b0;
        end else begin
            frame_hit <= 1'b0;
            if (!listen) begin
                // a transfer is running, control is ignored
                capturing <= 1'b0;
                bit_cnt   <= '0;
            end else if (last_bit) begin
                capturing   <= 1'b0;
                bit_cnt     <= '0;
                frame_hit   <= start_ok && (frame_id == slave_id_t'(SLAVE_ID));
                frame_write <= frame_full[0];
            end else if (capturing) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else if (control) begin
                // first bit of the start pattern
                capturing <= 1'b1;
                bit_cnt   <= frame_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (listen && (capturing || control)) begin
            frame_sr <= frame_full[CON_BITS-2:0];
        end
    end

    // the sequencer must still be idle when a hit is reported
    hit_while_listening: assert property (
        @(posedge clk) disable iff (!rstN)
        frame_hit |-> listen
    ) else $error("frame_hit raised while the sequencer was busy");

endmodule

//--- source/read_channel.sv
`timescale 1ns/1ps

module read_channel
    import slave_pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        read_go,
    input  logic        g_rxDone,
    input  logic        g_txReady,
    input  word_t       g_byteFromRx,
    input  ack_status_t status_nibble,
    output logic        g_txStart,
    output logic        rD,
    output logic        shifting,
    output logic        read_done,
    output word_t       g_byteForTx
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT,
        R_ACK,
        R_STREAM
    } rd_state_t;

    typedef logic [$clog2(STATUS_BITS + DATA_WIDTH + 1)-1:0] stream_cnt_t;

    rd_state_t                             state;
    stream_cnt_t                           bit_cnt;
    logic [STATUS_BITS+DATA_WIDTH-1:0]     stream_sr;
    logic                                  load_stream;
    logic                                  first_bit;
    logic                                  last_bit;

    assign shifting    = (state == R_STREAM);
    assign load_stream = (state == R_WAIT) && g_rxDone;
    assign first_bit   = (state == R_ACK) && g_txReady;
    assign last_bit    = shifting && (bit_cnt == stream_cnt_t'(STATUS_BITS + DATA_WIDTH));

    // the previous board only ever gets an ACK from us
    assign g_byteForTx = word_t'(ACK_CODE);
    assign g_txStart   = first_bit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= R_IDLE;
            bit_cnt   <= '0;
            rD        <= 1'b0;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (read_go) begin
                        state <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (g_rxDone) begin
                        state <= R_ACK;
                    end
                end
                R_ACK: begin
                    // status msb leaves together with the ACK start
                    if (g_txReady) begin
                        rD      <= stream_sr[STATUS_BITS+DATA_WIDTH-1];
                        bit_cnt <= stream_cnt_t'(1);
                        state   <= R_STREAM;
                    end
                end
                R_STREAM: begin
                    if (last_bit) begin
                        rD        <= 1'b0;
                        bit_cnt   <= '0;
                        read_done <= 1'b1;
                        state     <= R_IDLE;
                    end else begin
                        rD      <= stream_sr[STATUS_BITS+DATA_WIDTH-1];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    // status of the last write goes out ahead of the word
    always_ff @(posedge clk) begin
        if (load_stream) begin
            stream_sr <= {status_nibble, g_byteFromRx};
        end else if (first_bit || shifting) begin
            stream_sr <= {stream_sr[STATUS_BITS+DATA_WIDTH-2:0], 1'b0};
        end
    end

    ack_start_backpressure: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(g_txStart) |-> g_txReady
    ) else $error("g_txStart raised while g_txReady was low");

endmodule

//--- source/slave_pkg.sv
package slave_pkg;

    // bus geometry
    localparam int DATA_WIDTH = 32;
    localparam int SLAVES     = 3;
    localparam int S_ID_WIDTH = $clog2(SLAVES + 1);
    localparam int SLAVE_ID   = 1;

    // start pattern, id, r/w bit
    localparam int CON_BITS   = 3 + S_ID_WIDTH + 1;

    localparam logic [2:0] START_CODE = 3'b111;

    // handshake bytes exchanged with the neighbouring boards
    localparam logic [7:0] ACK_CODE = 8'b11001100;
    localparam logic [7:0] NAK_CODE = 8'b10101010;

    // status sent to the master is the upper nibble of the code
    localparam int STATUS_BITS = 4;

    // retransmission on the send side
    localparam int ACK_TIMEOUT = 200;
    localparam int RETX_LIMIT  = 3;

    typedef logic [DATA_WIDTH-1:0]  word_t;
    typedef logic [S_ID_WIDTH-1:0]  slave_id_t;
    typedef logic [STATUS_BITS-1:0] ack_status_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ
    } seq_state_t;

endpackage

//--- source/slave_sequencer.sv
`timescale 1ns/1ps

module slave_sequencer
    import slave_pkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic frame_hit,
    input  logic frame_write,
    input  logic write_done,
    input  logic read_done,
    input  logic accepting,
    input  logic shifting,
    output logic listen,
    output logic write_go,
    output logic read_go,
    output logic ready
);

    seq_state_t state;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            write_go <= 1'b0;
            read_go  <= 1'b0;
        end else begin
            write_go <= 1'b0;
            read_go  <= 1'b0;
            case (state)
                IDLE: begin
                    if (frame_hit) begin
                        if (frame_write) begin
                            state    <= WRITE;
                            write_go <= 1'b1;
                        end else begin
                            state   <= READ;
                            read_go <= 1'b1;
                        end
                    end
                end
                WRITE: begin
                    if (write_done) begin
                        state <= IDLE;
                    end
                end
                READ: begin
                    if (read_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // control frames are only decoded between transfers
    assign listen = (state == IDLE);

    // ready follows the channel that owns the bus in each state
    always_comb begin
        ready = 1'b0;
        case (state)
            IDLE:    ready = 1'b1;
            WRITE:   ready = accepting;
            READ:    ready = shifting;
            default: ready = 1'b0;
        endcase
    end

    go_exclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(write_go && read_go)
    ) else $error("write_go and read_go raised together");

    // a done pulse may only come from the channel that was started
    done_matches_state: assert property (
        @(posedge clk) disable iff (!rstN)
        (write_done |-> state == WRITE) and (read_done |-> state == READ)
    ) else $error("done pulse from a channel that is not active");

endmodule

//--- source/uart_slave.sv
`timescale 1ns/1ps

module uart_slave
    import slave_pkg::*;
(
    input  logic  clk,
    input  logic  rstN,

    // master side
    input  logic  control,
    input  logic  wD,
    input  logic  valid,
    output logic  rD,
    output logic  ready,
    output logic  received_ack,

    // send side uart, towards the next board
    output logic  s_txStart,
    output word_t s_byteForTx,
    input  logic  s_txReady,
    input  logic  s_rxDone,
    input  word_t s_byteFromRx,

    // get side uart, from the previous board
    output logic  g_txStart,
    output word_t g_byteForTx,
    input  logic  g_txReady,
    input  logic  g_rxDone,
    input  word_t g_byteFromRx
);

    logic        listen;
    logic        frame_hit;
    logic        frame_write;
    logic        write_go;
    logic        read_go;
    logic        write_done;
    logic        read_done;
    logic        accepting;
    logic        shifting;
    ack_status_t status_nibble;

    frame_decoder frame_decoder_i (
        .clk         (clk),
        .rstN        (rstN),
        .control     (control),
        .listen      (listen),
        .frame_hit   (frame_hit),
        .frame_write (frame_write)
    );

    slave_sequencer slave_sequencer_i (
        .clk         (clk),
        .rstN        (rstN),
        .frame_hit   (frame_hit),
        .frame_write (frame_write),
        .write_done  (write_done),
        .read_done   (read_done),
        .accepting   (accepting),
        .shifting    (shifting),
        .listen      (listen),
        .write_go    (write_go),
        .read_go     (read_go),
        .ready       (ready)
    );

    write_channel write_channel_i (
        .clk           (clk),
        .rstN          (rstN),
        .write_go      (write_go),
        .valid         (valid),
        .wD            (wD),
        .s_txReady     (s_txReady),
        .s_rxDone      (s_rxDone),
        .s_byteFromRx  (s_byteFromRx),
        .s_txStart     (s_txStart),
        .accepting     (accepting),
        .write_done    (write_done),
        .received_ack  (received_ack),
        .s_byteForTx   (s_byteForTx),
        .status_nibble (status_nibble)
    );

    read_channel read_channel_i (
        .clk           (clk),
        .rstN          (rstN),
        .read_go       (read_go),
        .g_rxDone      (g_rxDone),
        .g_txReady     (g_txReady),
        .g_byteFromRx  (g_byteFromRx),
        .status_nibble (status_nibble),
        .g_txStart     (g_txStart),
        .rD            (rD),
        .shifting      (shifting),
        .read_done     (read_done),
        .g_byteForTx   (g_byteForTx)
    );

endmodule

//--- source/write_channel.sv
`timescale 1ns/1ps

module write_channel
    import slave_pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        write_go,
    input  logic        valid,
    input  logic        wD,
    input  logic        s_txReady,
    input  logic        s_rxDone,
    input  word_t       s_byteFromRx,
    output logic        s_txStart,
    output logic        accepting,
    output logic        write_done,
    output logic        received_ack,
    output word_t       s_byteForTx,
    output ack_status_t status_nibble
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_SHIFT,
        W_SEND,
        W_WAIT
    } wr_state_t;

    typedef logic [$clog2(DATA_WIDTH)-1:0]   bit_cnt_t;
    typedef logic [$clog2(ACK_TIMEOUT)-1:0]  timer_t;
    typedef logic [$clog2(RETX_LIMIT+1)-1:0] retx_cnt_t;

    wr_state_t           state;
    bit_cnt_t            bit_cnt;
    timer_t              ack_timer;
    retx_cnt_t           retx_cnt;
    logic [DATA_WIDTH-2:0] word_sr;
    logic                last_bit;
    logic                ack_match;

    assign accepting = (state == W_SHIFT);
    assign last_bit  = accepting && valid && (bit_cnt == bit_cnt_t'(DATA_WIDTH - 1));
    assign ack_match = (s_byteFromRx == word_t'(ACK_CODE));

    // start only goes out while the transmitter can take it
    assign s_txStart = (state == W_SEND) && s_txReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state         <= W_IDLE;
            bit_cnt       <= '0;
            ack_timer     <= '0;
            retx_cnt      <= '0;
            write_done    <= 1'b0;
            received_ack  <= 1'b0;
            status_nibble <= '0;
        end else begin
            write_done <= 1'b0;
            case (state)
                W_IDLE: begin
                    if (write_go) begin
                        state    <= W_SHIFT;
                        bit_cnt  <= '0;
                        retx_cnt <= '0;
                    end
                end
                W_SHIFT: begin
                    // gaps in valid just stall the count
                    if (valid) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (last_bit) begin
                        state <= W_SEND;
                    end
                end
                W_SEND: begin
                    if (s_txReady) begin
                        // the start cycle counts as the first timeout cycle
                        ack_timer <= timer_t'(1);
                        state     <= W_WAIT;
                    end
                end
                W_WAIT: begin
                    if (s_rxDone) begin
                        write_done    <= 1'b1;
                        received_ack  <= ack_match;
                        status_nibble <= ack_match ? ACK_CODE[7 -: STATUS_BITS]
                                                   : NAK_CODE[7 -: STATUS_BITS];
                        state         <= W_IDLE;
                    end else if (ack_timer == timer_t'(ACK_TIMEOUT - 1)) begin
                        if (retx_cnt == retx_cnt_t'(RETX_LIMIT)) begin
                            // peer never answered
                            write_done    <= 1'b1;
                            received_ack  <= 1'b0;
                            status_nibble <= NAK_CODE[7 -: STATUS_BITS];
                            state         <= W_IDLE;
                        end else begin
                            retx_cnt <= retx_cnt + 1'b1;
                            state    <= W_SEND;
                        end
                    end else begin
                        ack_timer <= ack_timer + 1'b1;
                    end
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

    // word shifted in msb first and handed to the uart after the last bit
    always_ff @(posedge clk) begin
        if (accepting && valid) begin
            word_sr <= {word_sr[DATA_WIDTH-3:0], wD};
        end
        if (last_bit) begin
            s_byteForTx <= {word_sr, wD};
        end
    end

    tx_start_backpressure: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(s_txStart) |-> s_txReady
    ) else $error("s_txStart raised while s_txReady was low");

endmodule

//--- tests/tb_uart_slave.sv
`timescale 1ns/1ps

module tb_uart_slave
    import slave_pkg::*;
();

    localparam int STREAM_BITS  = STATUS_BITS + DATA_WIDTH;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_DELAY    = 4;
    localparam int HOLD_CYCLES  = 25;
    // one transfer with gaps and holds fits well inside this
    localparam int XFER_BUDGET  = 200;
    localparam int RUN_BUDGET   = RESET_CYCLES + 8 * XFER_BUDGET
                                  + (1 + RETX_LIMIT) * ACK_TIMEOUT;
    localparam int CYCLE_LIMIT  = 2 * RUN_BUDGET;

    logic  clk = 1'b0;
    logic  rstN;
    logic  control;
    logic  wD;
    logic  valid;
    logic  rD;
    logic  ready;
    logic  received_ack;
    logic  s_txStart;
    word_t s_byteForTx;
    logic  s_txReady;
    logic  s_rxDone;
    word_t s_byteFromRx;
    logic  g_txStart;
    word_t g_byteForTx;
    logic  g_txReady;
    logic  g_rxDone;
    word_t g_byteFromRx;

    logic [31:0]            rng_state;
    logic                   ack_enable;
    logic                   stream_armed;
    logic                   last_acked;
    logic [STREAM_BITS-1:0] exp_stream;
    word_t                  s_tx_seen;
    word_t                  word;
    int rd_count     = 0;
    int s_starts     = 0;
    int g_starts     = 0;
    int cmp_errors   = 0;
    int main_errors  = 0;
    int cycles       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int errors_at_start;
    int s_before;
    int g_before;

    uart_slave dut_i (
        .clk          (clk),
        .rstN         (rstN),
        .control      (control),
        .wD           (wD),
        .valid        (valid),
        .rD           (rD),
        .ready        (ready),
        .received_ack (received_ack),
        .s_txStart    (s_txStart),
        .s_byteForTx  (s_byteForTx),
        .s_txReady    (s_txReady),
        .s_rxDone     (s_rxDone),
        .s_byteFromRx (s_byteFromRx),
        .g_txStart    (g_txStart),
        .g_byteForTx  (g_byteForTx),
        .g_txReady    (g_txReady),
        .g_rxDone     (g_rxDone),
        .g_byteFromRx (g_byteFromRx)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // status nibble of the last write, then the word, msb first
    function automatic logic [STREAM_BITS-1:0] expected_stream(input logic acked,
                                                               input word_t data);
        ack_status_t status;
        status = acked ? ACK_CODE[7 -: STATUS_BITS] : NAK_CODE[7 -: STATUS_BITS];
        return {status, data};
    endfunction

    task automatic check_that(input logic ok, input string what);
        assert (ok) else begin
            $display("CHECK FAILED at %0t ns: %s", $time, what);
            main_errors++;
        end
    endtask

    task automatic start_test();
        errors_at_start = main_errors + cmp_errors;
        tests_run++;
    endtask

    task automatic finish_test(input string name);
        int new_errors;
        new_errors = main_errors + cmp_errors - errors_at_start;
        if (new_errors == 0) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: failed, %0d checks", tests_run, name, new_errors);
            tests_failed++;
        end
    endtask

    task automatic draw_word(output word_t w);
        rng_state = lcg_next(rng_state);
        w = rng_state;
    endtask

    task automatic wait_ready(input logic level);
        while (ready !== level) begin
            @(negedge clk);
        end
    endtask

    // start pattern, id, r/w bit on consecutive cycles
    task automatic send_frame(input logic [2:0] start_bits, input slave_id_t id,
                              input logic write);
        logic [CON_BITS-1:0] frame;
        frame = {start_bits, id, write};
        for (int i = CON_BITS - 1; i >= 0; i--) begin
            control = frame[i];
            @(negedge clk);
        end
        control = 1'b0;
    endtask

    // about one bit in four is preceded by a gap in valid
    task automatic shift_word(input word_t data);
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            rng_state = lcg_next(rng_state);
            if (rng_state[31:30] == 2'b00) begin
                valid = 1'b0;
                wD    = rng_state[15];
                @(negedge clk);
            end
            valid = 1'b1;
            wD    = data[i];
            @(negedge clk);
        end
        valid = 1'b0;
        wD    = 1'b0;
    endtask

    task automatic run_write(input word_t data, input logic peer_acks, input int hold);
        int starts_before;
        int expected_starts;
        starts_before   = s_starts;
        expected_starts = peer_acks ? 1 : 1 + RETX_LIMIT;
        ack_enable      = peer_acks;
        if (hold > 0) begin
            s_txReady = 1'b0;
        end
        send_frame(START_CODE, slave_id_t'(SLAVE_ID), 1'b1);
        wait_ready(1'b0);
        wait_ready(1'b1);
        shift_word(data);
        if (hold > 0) begin
            repeat (hold) @(negedge clk);
            check_that(s_starts == starts_before, "s_txStart pulsed while s_txReady was low");
            s_txReady = 1'b1;
        end
        wait_ready(1'b1);
        check_that(s_starts - starts_before == expected_starts,
                   $sformatf("%0d s_txStart pulses, expected %0d",
                             s_starts - starts_before, expected_starts));
        check_that(s_tx_seen == data,
                   $sformatf("s_byteForTx %h, expected %h", s_tx_seen, data));
        check_that(received_ack == peer_acks,
                   $sformatf("received_ack %b, expected %b", received_ack, peer_acks));
        last_acked = peer_acks;
    endtask

    task automatic run_read(input word_t data, input int hold);
        int starts_before;
        starts_before = g_starts;
        exp_stream    = expected_stream(last_acked, data);
        if (hold > 0) begin
            g_txReady = 1'b0;
        end
        send_frame(START_CODE, slave_id_t'(SLAVE_ID), 1'b0);
        wait_ready(1'b0);
        repeat (3) @(negedge clk);
        g_byteFromRx = data;
        g_rxDone     = 1'b1;
        stream_armed = 1'b1;
        @(negedge clk);
        g_rxDone = 1'b0;
        if (hold > 0) begin
            repeat (hold) @(negedge clk);
            check_that(g_starts == starts_before, "g_txStart pulsed while g_txReady was low");
            check_that(ready == 1'b0, "ready high before the ACK went out");
            g_txReady = 1'b1;
        end
        while (rd_count < STREAM_BITS) begin
            @(negedge clk);
        end
        stream_armed = 1'b0;
        check_that(g_starts - starts_before == 1,
                   $sformatf("%0d g_txStart pulses, expected 1", g_starts - starts_before));
        wait_ready(1'b1);
    endtask

    task automatic watch_ready_high(input int n);
        repeat (n) begin
            @(negedge clk);
            check_that(ready == 1'b1, "ready dropped after a frame for another slave");
        end
    endtask

    // send side receiver, answers each start with an ACK unless silenced
    initial begin
        s_rxDone     = 1'b0;
        s_byteFromRx = '0;
        forever begin
            @(posedge clk);
            if (s_txStart && ack_enable) begin
                repeat (ACK_DELAY) @(negedge clk);
                s_byteFromRx = word_t'(ACK_CODE);
                s_rxDone     = 1'b1;
                @(negedge clk);
                s_rxDone = 1'b0;
            end
        end
    end

    // start pulses and the rD stream, compared as the DUT samples them
    always @(posedge clk) begin
        if (rstN) begin
            if (s_txStart) begin
                s_starts++;
                s_tx_seen = s_byteForTx;
                assert (s_txReady) else begin
                    $display("CHECK FAILED at %0t ns: s_txStart with s_txReady low", $time);
                    cmp_errors++;
                end
                assert (!ready) else begin
                    $display("CHECK FAILED at %0t ns: ready high during ACK wait", $time);
                    cmp_errors++;
                end
            end
            if (g_txStart) begin
                g_starts++;
                assert (g_txReady && g_byteForTx == word_t'(ACK_CODE)) else begin
                    $display("CHECK FAILED at %0t ns: g_txStart with ready %b byte %h",
                             $time, g_txReady, g_byteForTx);
                    cmp_errors++;
                end
            end
        end
        if (!stream_armed) begin
            rd_count = 0;
        end else if (ready && rd_count < STREAM_BITS) begin
            assert (rD == exp_stream[STREAM_BITS-1-rd_count]) else begin
                $display("CHECK FAILED at %0t ns: rD bit %0d is %b, expected %b",
                         $time, rd_count, rD, exp_stream[STREAM_BITS-1-rd_count]);
                cmp_errors++;
            end
            rd_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rng_state    = 32'h995;
        rstN         = 1'b0;
        control      = 1'b0;
        wD           = 1'b0;
        valid        = 1'b0;
        s_txReady    = 1'b1;
        g_txReady    = 1'b1;
        g_rxDone     = 1'b0;
        g_byteFromRx = '0;
        ack_enable   = 1'b1;
        stream_armed = 1'b0;
        last_acked   = 1'b0;
        exp_stream   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        start_test();
        check_that(ready == 1'b1, "ready low after reset");
        check_that(!s_txStart && !g_txStart, "start pulse after reset");
        check_that(received_ack == 1'b0, "received_ack high after reset");
        check_that(rD == 1'b0, "rD high after reset");
        finish_test("reset state");

        start_test();
        draw_word(word);
        run_write(word, 1'b1, 0);
        finish_test("write with ACK");

        start_test();
        draw_word(word);
        run_read(word, 0);
        finish_test("read after ACK write");

        start_test();
        draw_word(word);
        run_write(word, 1'b0, 0);
        draw_word(word);
        run_read(word, 0);
        finish_test("write without ACK, then read");

        start_test();
        s_before = s_starts;
        g_before = g_starts;
        send_frame(START_CODE, slave_id_t'(2), 1'b1);
        watch_ready_high(10);
        send_frame(START_CODE, slave_id_t'(0), 1'b0);
        watch_ready_high(10);
        send_frame(3'b101, slave_id_t'(SLAVE_ID), 1'b1);
        watch_ready_high(10);
        send_frame(3'b110, slave_id_t'(SLAVE_ID), 1'b0);
        watch_ready_high(10);
        check_that(s_starts == s_before && g_starts == g_before,
                   "start pulse after a frame that was not for this slave");
        finish_test("foreign id and bad start pattern");

        start_test();
        draw_word(word);
        run_write(word, 1'b1, HOLD_CYCLES);
        draw_word(word);
        run_read(word, HOLD_CYCLES);
        finish_test("back-pressure on both UARTs");

        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 tests_run, tests_failed, main_errors + cmp_errors);
        if (main_errors + cmp_errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
